/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_core
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
common/core_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/exec.sv
verilog/mem.sv
verilog/registerfile.sv
verilog/core.sv
verification/tb_clock.sv
verification/tb_core.sv

/* common/core_pkg.sv */
package core_pkg;

    // ************************************************************************
    // basic types
    // ************************************************************************

    typedef logic [31:0] word_t;     // data or address word.
    typedef logic [4:0]  reg_idx_t;  // register index.
    typedef logic [3:0]  alu_op_t;   // alu operation code.

    typedef enum logic [2:0] {
        ST_FETCH  = 3'd0,
        ST_DECODE = 3'd1,
        ST_EXEC   = 3'd2,
        ST_MEM    = 3'd3,
        ST_WB     = 3'd4
    } state_t;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0.

    // rv32i major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SRL    = 4'd5;
    localparam alu_op_t ALU_SRA    = 4'd6;
    localparam alu_op_t ALU_OR     = 4'd7;
    localparam alu_op_t ALU_AND    = 4'd8;
    localparam alu_op_t ALU_PASS_B = 4'd9;

    // ************************************************************************
    // stage records
    // ************************************************************************

    typedef struct packed {
        alu_op_t    alu_op;
        logic       alu_src_imm;      // operand b from the immediate.
        logic       a_is_pc;          // operand a from the pc.
        logic       branch_c;         // conditional branch.
        logic [2:0] funct3;           // branch condition.
        logic       branch_uc;        // jal or jalr.
        logic       branch_relative;  // target is pc based.
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       link;             // write pc+4 to rd.
    } ctrl_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        logic     branch_taken;
        word_t    branch_addr;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        reg_idx_t write_reg;
    } ex_mem_t;

    typedef struct packed {
        word_t    write_data;
        reg_idx_t write_reg;
        logic     reg_write;
        logic     branch_taken;
        word_t    branch_addr;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     reg_write;
        reg_idx_t rd;
        word_t    rd_data;
    } commit_t;

endpackage

/* program.hex */
// one 32-bit instruction word per line, from address 0 upward
// each word is followed by its assembly
00500093  // 00: addi x1, x0, 5
ffd00113  // 04: addi x2, x0, -3
123451b7  // 08: lui x3, 0x12345
00001217  // 0c: auipc x4, 0x1
402082b3  // 10: sub x5, x1, x2
40115333  // 14: sra x6, x2, x1
001123b3  // 18: slt x7, x2, x1
00302423  // 1c: sw x3, 8(x0)
00502623  // 20: sw x5, 12(x0)
00802403  // 24: lw x8, 8(x0)
00c02483  // 28: lw x9, 12(x0)
00708013  // 2c: addi x0, x1, 7
00000463  // 30: beq x0, x0, +8
00100513  // 34: addi x10, x0, 1
00109463  // 38: bne x1, x1, +8
00114463  // 3c: blt x2, x1, +8
00200513  // 40: addi x10, x0, 2
00115463  // 44: bge x2, x1, +8
008005ef  // 48: jal x11, +8
00300513  // 4c: addi x10, x0, 3
06100613  // 50: addi x12, x0, 0x61
000606e7  // 54: jalr x13, 0(x12)
00400513  // 58: addi x10, x0, 4
00500513  // 5c: addi x10, x0, 5
00109733  // 60: sll x14, x1, x1
001157b3  // 64: srl x15, x2, x1
0021f833  // 68: and x16, x3, x2
001008b3  // 6c: add x17, x0, x1
ffe12913  // 70: slti x18, x2, -2
0000006f  // 74: jal x0, 0

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released on a falling edge.
    end

endmodule

/* verification/tb_core.sv */
`timescale 1ns/1ps

module tb_core;

    import core_pkg::*;

    localparam int NUM_COMMITS    = 200;
    localparam int TIMEOUT_CYCLES = NUM_COMMITS * 5 + 50;

    logic    clk;
    logic    rst;
    commit_t commit;

    word_t imem_model [IMEM_WORDS];
    word_t dmem_model [DMEM_WORDS];
    word_t regs_model [32];
    word_t pc_model;
    int    cycle_count = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    core u_core (
        .clk    (clk),
        .rst    (rst),
        .commit (commit)
    );

    initial begin
        $readmemh("program.hex", imem_model);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_model[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            regs_model[i] = '0;
        end
        pc_model = '0;
    end

    // ************************************************************************
    // isa reference model
    // ************************************************************************

    function automatic commit_t model_step();
        commit_t    exp;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      addr;
        word_t      val;
        word_t      next_pc;
        logic [2:0] f3;
        reg_idx_t   rd;
        logic       wr;
        logic       take;
        ins     = imem_model[pc_model[9:2]];
        f3      = ins[14:12];
        rd      = ins[11:7];
        a       = regs_model[ins[19:15]];
        b       = regs_model[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        wr      = 1'b1;
        val     = '0;
        next_pc = pc_model + 32'd4;
        case (ins[6:0])
            OP_LUI:   val = {ins[31:12], 12'b0};
            OP_AUIPC: val = pc_model + {ins[31:12], 12'b0};
            OP_JAL: begin
                val     = pc_model + 32'd4;
                next_pc = pc_model + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                val     = pc_model + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;  // target bit 0 dropped.
            end
            OP_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    default: take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc_model + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OP_LOAD: begin
                addr = a + imm_i;
                val  = dmem_model[addr[9:2]];
            end
            OP_STORE: begin
                wr   = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dmem_model[addr[9:2]] = b;
            end
            OP_IMM: begin
                case (f3)
                    3'b000:  val = a + imm_i;
                    3'b010:  val = {31'b0, $signed(a) < $signed(imm_i)};
                    3'b100:  val = a ^ imm_i;
                    3'b110:  val = a | imm_i;
                    3'b111:  val = a & imm_i;
                    default: wr = 1'b0;
                endcase
            end
            OP_REG: begin
                case (f3)
                    3'b000:  val = ins[30] ? a - b : a + b;
                    3'b001:  val = a << b[4:0];
                    3'b010:  val = {31'b0, $signed(a) < $signed(b)};
                    3'b100:  val = a ^ b;
                    3'b101: begin
                        val = a >> b[4:0];
                        if (ins[30] && a[31]) begin
                            val = val | ~(32'hffff_ffff >> b[4:0]);  // sign fill for sra.
                        end
                    end
                    3'b110:  val = a | b;
                    3'b111:  val = a & b;
                    default: wr = 1'b0;
                endcase
            end
            default: wr = 1'b0;  // anything else is a no-op.
        endcase
        if (wr && rd != '0) begin
            regs_model[rd] = val;
        end
        exp.valid     = 1'b1;
        exp.pc        = pc_model;
        exp.reg_write = wr;
        exp.rd        = wr ? rd : '0;
        exp.rd_data   = (wr && rd != '0) ? val : '0;
        pc_model      = next_pc;
        return exp;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // ************************************************************************
    // commit checker
    // ************************************************************************

    initial begin : compare
        commit_t exp;
        int      since_commit;
        int      commits;
        commits = 0;
        @(posedge clk);
        @(negedge clk);
        check_value("commit.valid", {31'b0, commit.valid}, 32'd0);  // still in reset.
        @(negedge rst);
        since_commit = 1;
        while (commits < NUM_COMMITS) begin
            @(negedge clk);
            since_commit++;
            if (commit.valid) begin
                if (since_commit != 5) begin
                    $display("commit %0d came %0d cycles after the previous one instead of 5",
                             commits, since_commit);
                    $display("=== FAIL ===");
                    $fatal(1);
                end
                exp = model_step();
                check_value("commit.pc", commit.pc, exp.pc);
                check_value("commit.reg_write", {31'b0, commit.reg_write}, {31'b0, exp.reg_write});
                check_value("commit.rd", {27'b0, commit.rd}, {27'b0, exp.rd});
                check_value("commit.rd_data", commit.rd_data, exp.rd_data);
                since_commit = 0;
                commits++;
            end
        end
        $display("=== PASS ===");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: %0d cycles passed before all %0d commits were seen",
                     cycle_count, NUM_COMMITS);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ps

module core (
    input  logic              clk,
    input  logic              rst,
    output core_pkg::commit_t commit
);

    import core_pkg::*;

    state_t   state;
    word_t    pc;
    word_t    instr;
    ctrl_t    ctrl;
    word_t    imm;
    reg_idx_t read_reg1;
    reg_idx_t read_reg2;
    reg_idx_t write_reg;
    word_t    reg1_data;
    word_t    reg2_data;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     rf_write_enable;

    // ************************************************************************
    // state machine and pc
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_FETCH;
            pc    <= '0;
        end else begin
            unique case (state)
                ST_FETCH:  state <= ST_DECODE;
                ST_DECODE: state <= ST_EXEC;
                ST_EXEC:   state <= ST_MEM;
                ST_MEM:    state <= ST_WB;
                ST_WB: begin
                    state <= ST_FETCH;
                    pc    <= mem_wb.branch_taken ? mem_wb.branch_addr : pc + 32'd4;
                end
                default:   state <= ST_FETCH;
            endcase
        end
    end

    // one full instruction round, fetch back to fetch in five cycles
    a_state_seq: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_FETCH |=> state == ST_DECODE ##1 state == ST_EXEC
            ##1 state == ST_MEM ##1 state == ST_WB ##1 state == ST_FETCH
    );

    assign rf_write_enable = (state == ST_WB) && mem_wb.reg_write;

    // ************************************************************************
    // stages
    // ************************************************************************

    fetch u_fetch (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .pc    (pc),
        .instr (instr)
    );

    decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .instr     (instr),
        .ctrl      (ctrl),
        .imm       (imm),
        .read_reg1 (read_reg1),
        .read_reg2 (read_reg2),
        .write_reg (write_reg)
    );

    registerfile u_registerfile (
        .clk          (clk),
        .rst          (rst),
        .read_reg1    (read_reg1),
        .read_reg2    (read_reg2),
        .write_reg    (mem_wb.write_reg),
        .write_data   (mem_wb.write_data),
        .write_enable (rf_write_enable),
        .reg1_data    (reg1_data),
        .reg2_data    (reg2_data)
    );

    exec u_exec (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .pc        (pc),
        .ctrl      (ctrl),
        .imm       (imm),
        .reg1_data (reg1_data),
        .reg2_data (reg2_data),
        .write_reg (write_reg),
        .ex_mem    (ex_mem)
    );

    mem u_mem (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    // retirement report, pc still holds the retiring instruction in ST_WB.
    always_comb begin
        commit.valid     = (state == ST_WB);
        commit.pc        = pc;
        commit.reg_write = mem_wb.reg_write;
        commit.rd        = mem_wb.reg_write ? mem_wb.write_reg : '0;
        commit.rd_data   = (mem_wb.reg_write && mem_wb.write_reg != '0) ? mem_wb.write_data
                                                                         : '0;
    end

endmodule

/* verilog/decode.sv */
`timescale 1ns/1ps

module decode (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::state_t   state,
    input  core_pkg::word_t    instr,
    output core_pkg::ctrl_t    ctrl,
    output core_pkg::word_t    imm,
    output core_pkg::reg_idx_t read_reg1,
    output core_pkg::reg_idx_t read_reg2,
    output core_pkg::reg_idx_t write_reg
);

    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_d;
    ctrl_t      ctrl_d;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ************************************************************************
    // immediates
    // ************************************************************************

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        unique case (opcode)
            OP_IMM, OP_LOAD, OP_JALR: imm_d = imm_i;
            OP_STORE:                 imm_d = imm_s;
            OP_BRANCH:                imm_d = imm_b;
            OP_LUI, OP_AUIPC:         imm_d = imm_u;
            OP_JAL:                   imm_d = imm_j;
            default:                  imm_d = '0;
        endcase
    end

    // ************************************************************************
    // control
    // ************************************************************************

    always_comb begin
        ctrl_d = '0;  // unknown forms retire as no-ops.
        ctrl_d.funct3 = funct3;
        ctrl_d.branch_relative = 1'b1;
        unique case (opcode)
            OP_LUI: begin
                ctrl_d.alu_op      = ALU_PASS_B;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.reg_write   = 1'b1;
            end
            OP_AUIPC: begin
                ctrl_d.alu_op      = ALU_ADD;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.a_is_pc     = 1'b1;
                ctrl_d.reg_write   = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                ctrl_d.alu_op          = ALU_ADD;
                ctrl_d.alu_src_imm     = 1'b1;
                ctrl_d.a_is_pc         = 1'b1;
                ctrl_d.branch_uc       = 1'b1;
                ctrl_d.branch_relative = (opcode == OP_JAL);
                ctrl_d.reg_write       = 1'b1;
                ctrl_d.link            = 1'b1;
            end
            OP_BRANCH: begin
                ctrl_d.alu_op   = ALU_SUB;
                ctrl_d.branch_c = 1'b1;
            end
            OP_LOAD: begin
                ctrl_d.alu_op      = ALU_ADD;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.mem_read    = 1'b1;
                ctrl_d.reg_write   = 1'b1;
            end
            OP_STORE: begin
                ctrl_d.alu_op      = ALU_ADD;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.mem_write   = 1'b1;
            end
            OP_IMM: begin
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.reg_write   = 1'b1;
                unique case (funct3)
                    3'b000:  ctrl_d.alu_op = ALU_ADD;
                    3'b010:  ctrl_d.alu_op = ALU_SLT;
                    3'b100:  ctrl_d.alu_op = ALU_XOR;
                    3'b110:  ctrl_d.alu_op = ALU_OR;
                    3'b111:  ctrl_d.alu_op = ALU_AND;
                    default: ctrl_d.reg_write = 1'b0;  // shifts, sltiu.
                endcase
            end
            OP_REG: begin
                ctrl_d.reg_write = 1'b1;
                unique case (funct3)
                    3'b000:  ctrl_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl_d.alu_op = ALU_SLL;
                    3'b010:  ctrl_d.alu_op = ALU_SLT;
                    3'b100:  ctrl_d.alu_op = ALU_XOR;
                    3'b101:  ctrl_d.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl_d.alu_op = ALU_OR;
                    3'b111:  ctrl_d.alu_op = ALU_AND;
                    default: ctrl_d.reg_write = 1'b0;  // sltu.
                endcase
            end
            default: ctrl_d.branch_relative = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl      <= '0;
            imm       <= '0;
            read_reg1 <= '0;
            read_reg2 <= '0;
            write_reg <= '0;
        end else if (state == ST_DECODE) begin
            ctrl      <= ctrl_d;
            imm       <= imm_d;
            read_reg1 <= instr[19:15];
            read_reg2 <= instr[24:20];
            write_reg <= instr[11:7];
        end
    end

endmodule

/* verilog/exec.sv */
`timescale 1ns/1ps

module exec (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::state_t   state,
    input  core_pkg::word_t    pc,
    input  core_pkg::ctrl_t    ctrl,
    input  core_pkg::word_t    imm,
    input  core_pkg::word_t    reg1_data,
    input  core_pkg::word_t    reg2_data,
    input  core_pkg::reg_idx_t write_reg,
    output core_pkg::ex_mem_t  ex_mem
);

    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t target_base;
    word_t target;
    logic  cond;

    assign op_a = ctrl.a_is_pc ? pc : reg1_data;
    assign op_b = ctrl.alu_src_imm ? imm : reg2_data;

    // ************************************************************************
    // alu
    // ************************************************************************

    always_comb begin
        unique case (ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch condition, signed only.
    always_comb begin
        unique case (ctrl.funct3)
            3'b000:  cond = (reg1_data == reg2_data);
            3'b001:  cond = (reg1_data != reg2_data);
            3'b100:  cond = ($signed(reg1_data) < $signed(reg2_data));
            3'b101:  cond = ($signed(reg1_data) >= $signed(reg2_data));
            default: cond = 1'b0;
        endcase
    end

    assign target_base = ctrl.branch_relative ? pc : reg1_data;
    assign target = (target_base + imm) & ~32'd1;  // bit 0 only ever set by jalr.

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (state == ST_EXEC) begin
            ex_mem.alu_result   <= ctrl.link ? pc + 32'd4 : alu_out;
            ex_mem.store_data   <= reg2_data;
            ex_mem.branch_taken <= ctrl.branch_uc | (ctrl.branch_c & cond);
            ex_mem.branch_addr  <= target;
            ex_mem.mem_read     <= ctrl.mem_read;
            ex_mem.mem_write    <= ctrl.mem_write;
            ex_mem.reg_write    <= ctrl.reg_write;
            ex_mem.write_reg    <= write_reg;
        end
    end

endmodule

/* verilog/fetch.sv */
`timescale 1ns/1ps

module fetch (
    input  logic             clk,
    input  logic             rst,
    input  core_pkg::state_t state,
    input  core_pkg::word_t  pc,
    output core_pkg::word_t  instr
);

    import core_pkg::*;

    word_t imem [IMEM_WORDS];

    initial begin
        $readmemh("program.hex", imem);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= NOP_INSTR;
        end else if (state == ST_FETCH) begin
            instr <= imem[pc[9:2]];  // word index.
        end
    end

    // the pc only ever moves by 4 or to a target with bits 1:0 clear
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        state == ST_FETCH |-> pc[1:0] == 2'b00
    );

endmodule

/* verilog/mem.sv */
`timescale 1ns/1ps

module mem (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::state_t  state,
    input  core_pkg::ex_mem_t ex_mem,
    output core_pkg::mem_wb_t mem_wb
);

    import core_pkg::*;

    word_t      dmem [DMEM_WORDS];
    logic [7:0] addr;

    assign addr = ex_mem.alu_result[9:2];  // word accesses only.

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_MEM && ex_mem.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else if (state == ST_MEM) begin
            mem_wb.write_data   <= ex_mem.mem_read ? dmem[addr] : ex_mem.alu_result;
            mem_wb.write_reg    <= ex_mem.write_reg;
            mem_wb.reg_write    <= ex_mem.reg_write;
            mem_wb.branch_taken <= ex_mem.branch_taken;
            mem_wb.branch_addr  <= ex_mem.branch_addr;
        end
    end

    // decode never sets both, exec must keep them apart
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(ex_mem.mem_read && ex_mem.mem_write)
    );

endmodule

/* verilog/registerfile.sv */
`timescale 1ns/1ps

module registerfile (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t read_reg1,
    input  core_pkg::reg_idx_t read_reg2,
    input  core_pkg::reg_idx_t write_reg,
    input  core_pkg::word_t    write_data,
    input  logic               write_enable,
    output core_pkg::word_t    reg1_data,
    output core_pkg::word_t    reg2_data
);

    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_reg != '0) begin
            regs[write_reg] <= write_data;  // x0 stays zero.
        end
    end

    assign reg1_data = regs[read_reg1];
    assign reg2_data = regs[read_reg2];

endmodule
